// ==== hdl/riscv_isa_pkg.sv ====
// RV32I base encodings only, FENCE, SYSTEM and all extensions are left out
`default_nettype none

package riscv_isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b000_0011,
        OPC_OPIMM  = 7'b001_0011,
        OPC_AUIPC  = 7'b001_0111,
        OPC_STORE  = 7'b010_0011,
        OPC_OP     = 7'b011_0011,
        OPC_LUI    = 7'b011_0111,
        OPC_BRANCH = 7'b110_0011,
        OPC_JALR   = 7'b110_0111,
        OPC_JAL    = 7'b110_1111
    } opcode_e;

    // Field positions (LSB) and widths
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_LSB = 25;
    localparam int FUNCT3_W   = 3;
    localparam int FUNCT7_W   = 7;

    // Immediate formats, FOUR is the link increment of JAL
    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_FOUR
    } imm_fmt_e;

    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;  // addi x0, x0, 0

endpackage

`default_nettype wire

// ==== hdl/decode_ctrl_pkg.sv ====
// Control encodings for the EX stage, alu_src has one shared code for IMM and PC
`default_nettype none

package decode_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    // Source 1 picks REG or PC, source 2 picks REG or IMM
    typedef enum logic {
        ALU_SRC_REG = 1'b0,
        ALU_SRC_ALT = 1'b1
    } alu_src_e;

    localparam alu_src_e ALU_SRC_PC  = ALU_SRC_ALT;
    localparam alu_src_e ALU_SRC_IMM = ALU_SRC_ALT;

    typedef enum logic [1:0] {
        WB_ALU    = 2'd0,
        WB_MEM    = 2'd1,
        WB_PCINCR = 2'd2
    } wb_sel_e;

    // Branch codes equal {0, funct3}
    typedef enum logic [3:0] {
        BR_BEQ  = 4'h0,
        BR_BNE  = 4'h1,
        BR_BLT  = 4'h4,
        BR_BGE  = 4'h5,
        BR_BLTU = 4'h6,
        BR_BGEU = 4'h7,
        BR_JALR = 4'h8,
        BR_NOP  = 4'hf
    } branch_e;

    // Same as the load/store funct3, 3'b111 marks no access
    typedef enum logic [2:0] {
        MEM_B    = 3'b000,
        MEM_H    = 3'b001,
        MEM_W    = 3'b010,
        MEM_BU   = 3'b100,
        MEM_HU   = 3'b101,
        MEM_NONE = 3'b111
    } mem_size_e;

    typedef struct packed {
        logic [riscv_isa_pkg::XLEN-1:0] pc;
        logic [riscv_isa_pkg::XLEN-1:0] instr;
    } fetch_t;

    typedef struct packed {
        logic [riscv_isa_pkg::XLEN-1:0]       pc;
        logic                                 alu_en;
        alu_op_e                              alu_op;
        alu_src_e                             alu_src_1;
        alu_src_e                             alu_src_2;
        logic [riscv_isa_pkg::REG_ADDR_W-1:0] rs1_addr;
        logic [riscv_isa_pkg::REG_ADDR_W-1:0] rs2_addr;
        logic [riscv_isa_pkg::XLEN-1:0]       rs1_data;
        logic [riscv_isa_pkg::XLEN-1:0]       rs2_data;
        logic [riscv_isa_pkg::XLEN-1:0]       imm;
        logic [riscv_isa_pkg::REG_ADDR_W-1:0] rd_addr;
        logic                                 rd_we;
        wb_sel_e                              wb_sel;
        logic                                 mem_req;
        logic                                 mem_we;
        mem_size_e                            mem_size;
        branch_e                              branch;
        logic                                 illegal;
    } decoded_t;

    // Idle EX slot
    localparam decoded_t DECODED_NOP = '{
        pc:        '0,
        alu_en:    1'b0,
        alu_op:    ALU_ADD,
        alu_src_1: ALU_SRC_REG,
        alu_src_2: ALU_SRC_REG,
        rs1_addr:  '0,
        rs2_addr:  '0,
        rs1_data:  '0,
        rs2_data:  '0,
        imm:       '0,
        rd_addr:   '0,
        rd_we:     1'b0,
        wb_sel:    WB_ALU,
        mem_req:   1'b0,
        mem_we:    1'b0,
        mem_size:  MEM_NONE,
        branch:    BR_NOP,
        illegal:   1'b0
    };

endpackage

`default_nettype wire

// ==== hdl/stage_reg.sv ====
// Stall holds and has priority over clear, reset and clear both load CLEAR_VAL
`default_nettype none

module stage_reg #(
    parameter type T         = logic,
    parameter T    CLEAR_VAL = '0
) (
    input  wire   clk,
    input  wire   arst_n_i,
    input  wire   stall_i,
    input  wire   clear_i,
    input  wire T d_i,
    output T      q_o
);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_o <= CLEAR_VAL;
        end else if (!stall_i) begin
            q_o <= clear_i ? CLEAR_VAL : d_i;  // Flush to a bubble
        end
    end

endmodule

`default_nettype wire

// ==== hdl/imm_gen.sv ====
// Purely combinational, formats outside imm_fmt_e give zero
`default_nettype none

module imm_gen (
    input  wire [riscv_isa_pkg::XLEN-1:0]  instr_i,
    input  wire riscv_isa_pkg::imm_fmt_e   fmt_i,
    output logic [riscv_isa_pkg::XLEN-1:0] imm_o,
    output logic [riscv_isa_pkg::XLEN-1:0] j_imm_o
);

    import riscv_isa_pkg::*;

    logic [XLEN-1:0] i_imm;
    logic [XLEN-1:0] s_imm;
    logic [XLEN-1:0] b_imm;
    logic [XLEN-1:0] u_imm;

    // All formats sign-extend from instr[31]
    assign i_imm   = {{20{instr_i[31]}}, instr_i[31:20]};
    assign s_imm   = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign b_imm   = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                      instr_i[11:8], 1'b0};
    assign u_imm   = {instr_i[31:12], 12'b0};
    assign j_imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                      instr_i[30:21], 1'b0};  // Also feeds the jump adder

    always_comb begin
        case (fmt_i)
            IMM_I:    imm_o = i_imm;
            IMM_S:    imm_o = s_imm;
            IMM_B:    imm_o = b_imm;
            IMM_U:    imm_o = u_imm;
            IMM_J:    imm_o = j_imm_o;
            IMM_FOUR: imm_o = XLEN'(4);
            default:  imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
// One write port with same-cycle bypass to both reads, x0 reads zero and drops writes
`default_nettype none

module reg_file (
    input  wire                                  clk,
    input  wire                                  arst_n_i,
    input  wire [riscv_isa_pkg::REG_ADDR_W-1:0]  raddr_a_i,
    input  wire [riscv_isa_pkg::REG_ADDR_W-1:0]  raddr_b_i,
    output logic [riscv_isa_pkg::XLEN-1:0]       rdata_a_o,
    output logic [riscv_isa_pkg::XLEN-1:0]       rdata_b_o,
    input  wire                                  we_i,
    input  wire [riscv_isa_pkg::REG_ADDR_W-1:0]  waddr_i,
    input  wire [riscv_isa_pkg::XLEN-1:0]        wdata_i
);

    import riscv_isa_pkg::*;

    logic [XLEN-1:0] regs_q [1:31];  // No storage for x0

    // Zero, then bypass, then array
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (we_i && (waddr_i == addr)) begin
            return wdata_i;
        end
        return regs_q[addr];
    endfunction

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    always_comb begin
        rdata_a_o = read_port(raddr_a_i);
        rdata_b_o = read_port(raddr_b_i);
    end

endmodule

`default_nettype wire

// ==== hdl/instr_decoder.sv ====
// RV32I without FENCE and SYSTEM, any illegal encoding has every enable low
`default_nettype none

module instr_decoder (
    input  wire [riscv_isa_pkg::XLEN-1:0]        instr_i,
    output logic                                 alu_en_o,
    output decode_ctrl_pkg::alu_op_e             alu_op_o,
    output decode_ctrl_pkg::alu_src_e            alu_src_1_o,
    output decode_ctrl_pkg::alu_src_e            alu_src_2_o,
    output logic [riscv_isa_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [riscv_isa_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    output logic [riscv_isa_pkg::REG_ADDR_W-1:0] rd_addr_o,
    output logic                                 rd_we_o,
    output decode_ctrl_pkg::wb_sel_e             wb_sel_o,
    output logic                                 mem_req_o,
    output logic                                 mem_we_o,
    output decode_ctrl_pkg::mem_size_e           mem_size_o,
    output decode_ctrl_pkg::branch_e             branch_o,
    output logic                                 jump_o,
    output riscv_isa_pkg::imm_fmt_e              imm_fmt_o,
    output logic                                 illegal_o
);

    import riscv_isa_pkg::*;
    import decode_ctrl_pkg::*;

    logic [FUNCT3_W-1:0] funct3;
    logic [FUNCT7_W-1:0] funct7;

    assign funct3     = instr_i[FUNCT3_LSB +: FUNCT3_W];
    assign funct7     = instr_i[FUNCT7_LSB +: FUNCT7_W];
    assign rs1_addr_o = instr_i[RS1_LSB +: REG_ADDR_W];
    assign rs2_addr_o = instr_i[RS2_LSB +: REG_ADDR_W];
    assign rd_addr_o  = instr_i[RD_LSB +: REG_ADDR_W];

    ////////////////////////////////////////////////////////////////////////////
    // Main decode
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        alu_en_o    = 1'b0;
        alu_op_o    = ALU_ADD;
        alu_src_1_o = ALU_SRC_REG;
        alu_src_2_o = ALU_SRC_REG;
        rd_we_o     = 1'b0;
        wb_sel_o    = WB_ALU;
        mem_req_o   = 1'b0;
        mem_we_o    = 1'b0;
        mem_size_o  = MEM_NONE;
        branch_o    = BR_NOP;
        jump_o      = 1'b0;
        imm_fmt_o   = IMM_I;
        illegal_o   = 1'b0;

        case (opcode_e'(instr_i[6:0]))
            OPC_LUI, OPC_AUIPC: begin
                alu_en_o    = 1'b1;
                alu_op_o    = (instr_i[5]) ? ALU_LUI : ALU_ADD;  // Bit 5 splits LUI from AUIPC
                alu_src_1_o = (instr_i[5]) ? ALU_SRC_REG : ALU_SRC_PC;
                alu_src_2_o = ALU_SRC_IMM;
                rd_we_o     = 1'b1;
                imm_fmt_o   = IMM_U;
            end
            OPC_JAL: begin  // Target resolved here, ALU forms pc + 4
                jump_o      = 1'b1;
                alu_en_o    = 1'b1;
                alu_src_1_o = ALU_SRC_PC;
                alu_src_2_o = ALU_SRC_IMM;
                rd_we_o     = 1'b1;
                imm_fmt_o   = IMM_FOUR;
            end
            OPC_JALR: begin
                alu_en_o    = 1'b1;
                alu_src_2_o = ALU_SRC_IMM;
                rd_we_o     = 1'b1;
                wb_sel_o    = WB_PCINCR;
                branch_o    = BR_JALR;
            end
            OPC_BRANCH: begin
                alu_en_o  = 1'b1;
                branch_o  = branch_e'({1'b0, funct3});
                imm_fmt_o = IMM_B;
                case (funct3)
                    3'b000, 3'b001, 3'b100, 3'b101: alu_op_o = ALU_SUB;
                    3'b110, 3'b111:                 alu_op_o = ALU_SUBU;
                    default:                        illegal_o = 1'b1;
                endcase
            end
            OPC_LOAD: begin
                alu_en_o    = 1'b1;
                alu_src_2_o = ALU_SRC_IMM;
                mem_req_o   = 1'b1;
                rd_we_o     = 1'b1;
                wb_sel_o    = WB_MEM;
                case (funct3)
                    3'b000, 3'b001, 3'b010, 3'b100, 3'b101: mem_size_o = mem_size_e'(funct3);
                    default: illegal_o = 1'b1;
                endcase
            end
            OPC_STORE: begin
                alu_en_o    = 1'b1;
                alu_src_2_o = ALU_SRC_IMM;  // rs1 + offset
                mem_req_o   = 1'b1;
                mem_we_o    = 1'b1;
                imm_fmt_o   = IMM_S;
                case (funct3)
                    3'b000, 3'b001, 3'b010: mem_size_o = mem_size_e'(funct3);
                    default:                illegal_o  = 1'b1;
                endcase
            end
            OPC_OPIMM: begin
                alu_en_o    = 1'b1;
                alu_src_2_o = ALU_SRC_IMM;
                rd_we_o     = 1'b1;
                case (funct3)
                    3'b000: alu_op_o = ALU_ADD;
                    3'b010: alu_op_o = ALU_SLT;
                    3'b011: alu_op_o = ALU_SLTU;
                    3'b100: alu_op_o = ALU_XOR;
                    3'b110: alu_op_o = ALU_OR;
                    3'b111: alu_op_o = ALU_AND;
                    3'b001: begin
                        alu_op_o  = ALU_SLL;
                        illegal_o = (funct7 != 7'h00);
                    end
                    default: begin  // SRLI and SRAI
                        alu_op_o  = (funct7[5]) ? ALU_SRA : ALU_SRL;
                        illegal_o = (funct7 != 7'h00) && (funct7 != 7'h20);
                    end
                endcase
            end
            OPC_OP: begin
                alu_en_o = 1'b1;
                rd_we_o  = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: alu_op_o = ALU_ADD;
                    {7'h20, 3'b000}: alu_op_o = ALU_SUB;
                    {7'h00, 3'b001}: alu_op_o = ALU_SLL;
                    {7'h00, 3'b010}: alu_op_o = ALU_SLT;
                    {7'h00, 3'b011}: alu_op_o = ALU_SLTU;
                    {7'h00, 3'b100}: alu_op_o = ALU_XOR;
                    {7'h00, 3'b101}: alu_op_o = ALU_SRL;
                    {7'h20, 3'b101}: alu_op_o = ALU_SRA;
                    {7'h00, 3'b110}: alu_op_o = ALU_OR;
                    {7'h00, 3'b111}: alu_op_o = ALU_AND;
                    default:         illegal_o = 1'b1;
                endcase
            end
            default: illegal_o = 1'b1;
        endcase

        // Squash side effects of a bad encoding
        if (illegal_o) begin
            alu_en_o   = 1'b0;
            rd_we_o    = 1'b0;
            mem_req_o  = 1'b0;
            mem_we_o   = 1'b0;
            jump_o     = 1'b0;
            branch_o   = BR_NOP;
            mem_size_o = MEM_NONE;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
// Decode stage, 2 cycles fetch to ex_o, jump_o valid from IF/ID content, no FENCE or SYSTEM
`default_nettype none

module decode_stage (
    input  wire                                  clk,
    input  wire                                  arst_n_i,
    input  wire                                  stall_i,
    input  wire                                  clear_i,
    input  wire decode_ctrl_pkg::fetch_t         fetch_i,
    input  wire                                  wb_we_i,
    input  wire [riscv_isa_pkg::REG_ADDR_W-1:0]  wb_addr_i,
    input  wire [riscv_isa_pkg::XLEN-1:0]        wb_data_i,
    output logic                                 jump_o,
    output logic [riscv_isa_pkg::XLEN-1:0]       jump_target_o,
    output decode_ctrl_pkg::decoded_t            ex_o
);

    import riscv_isa_pkg::*;
    import decode_ctrl_pkg::*;

    localparam fetch_t IF_ID_CLEAR = '{pc: '0, instr: NOP_INSTR};

    fetch_t          if_id_q;
    imm_fmt_e        imm_fmt;
    logic [XLEN-1:0] j_imm;
    wire decoded_t   id_d;    // Filled field by field below

    ////////////////////////////////////////////////////////////////////////////
    // IF/ID
    ////////////////////////////////////////////////////////////////////////////
    stage_reg #(
        .T         (fetch_t),
        .CLEAR_VAL (IF_ID_CLEAR)
    ) i_if_id (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stall_i  (stall_i),
        .clear_i  (clear_i),
        .d_i      (fetch_i),
        .q_o      (if_id_q)
    );

    instr_decoder i_instr_decoder (
        .instr_i     (if_id_q.instr),
        .alu_en_o    (id_d.alu_en),
        .alu_op_o    (id_d.alu_op),
        .alu_src_1_o (id_d.alu_src_1),
        .alu_src_2_o (id_d.alu_src_2),
        .rs1_addr_o  (id_d.rs1_addr),
        .rs2_addr_o  (id_d.rs2_addr),
        .rd_addr_o   (id_d.rd_addr),
        .rd_we_o     (id_d.rd_we),
        .wb_sel_o    (id_d.wb_sel),
        .mem_req_o   (id_d.mem_req),
        .mem_we_o    (id_d.mem_we),
        .mem_size_o  (id_d.mem_size),
        .branch_o    (id_d.branch),
        .jump_o      (jump_o),
        .imm_fmt_o   (imm_fmt),
        .illegal_o   (id_d.illegal)
    );

    imm_gen i_imm_gen (
        .instr_i (if_id_q.instr),
        .fmt_i   (imm_fmt),
        .imm_o   (id_d.imm),
        .j_imm_o (j_imm)
    );

    reg_file i_reg_file (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .raddr_a_i (id_d.rs1_addr),
        .raddr_b_i (id_d.rs2_addr),
        .rdata_a_o (id_d.rs1_data),
        .rdata_b_o (id_d.rs2_data),
        .we_i      (wb_we_i),
        .waddr_i   (wb_addr_i),
        .wdata_i   (wb_data_i)
    );

    assign id_d.pc       = if_id_q.pc;
    assign jump_target_o = if_id_q.pc + j_imm;  // JAL only

    ////////////////////////////////////////////////////////////////////////////
    // ID/EX
    ////////////////////////////////////////////////////////////////////////////
    stage_reg #(
        .T         (decoded_t),
        .CLEAR_VAL (DECODED_NOP)
    ) i_id_ex (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stall_i  (stall_i),
        .clear_i  (1'b0),     // Flushes arrive as a NOP from IF/ID
        .d_i      (id_d),
        .q_o      (ex_o)
    );

endmodule

`default_nettype wire

// ==== dv/tb_decode_stage.sv ====
// Random RV32I stimulus against a cycle model of the stage that ends at the first mismatch
`default_nettype none

module tb_decode_stage;

    import riscv_isa_pkg::*;
    import decode_ctrl_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int N_PHASES     = 5;
    localparam int PHASE_CYCLES = 250;
    localparam int DRAIN_CYCLES = 8;

    localparam fetch_t IF_ID_RESET = '{pc: '0, instr: NOP_INSTR};

    logic                  clk = 1'b0;
    logic                  arst_n;
    logic                  stall_i;
    logic                  clear_i;
    fetch_t                fetch_i;
    logic                  wb_we_i;
    logic [REG_ADDR_W-1:0] wb_addr_i;
    logic [XLEN-1:0]       wb_data_i;
    logic                  jump_o;
    logic [XLEN-1:0]       jump_target_o;
    decoded_t              ex_o;

    // Cycle model of the stage
    fetch_t          ifid_model;
    decoded_t        ex_exp;
    logic [XLEN-1:0] shadow [32];
    logic [31:0]     lcg_state = 32'hcb05_293a;

    always #(CLK_PERIOD / 2) clk = ~clk;

    decode_stage i_decode_stage (
        .clk           (clk),
        .arst_n_i      (arst_n),
        .stall_i       (stall_i),
        .clear_i       (clear_i),
        .fetch_i       (fetch_i),
        .wb_we_i       (wb_we_i),
        .wb_addr_i     (wb_addr_i),
        .wb_data_i     (wb_data_i),
        .jump_o        (jump_o),
        .jump_target_o (jump_target_o),
        .ex_o          (ex_o)
    );

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("Test failures found");
        $fatal(1);
    endtask

    // One word from the high halves of two LCG steps
    function automatic logic [31:0] next_rand();
        logic [15:0] hi;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        hi        = lcg_state[31:16];
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {hi, lcg_state[31:16]};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference decode
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [XLEN-1:0] imm_of(input logic [31:0] ins, input imm_fmt_e fmt);
        case (fmt)
            IMM_S:   return {{21{ins[31]}}, ins[30:25], ins[11:7]};
            IMM_B:   return {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            IMM_U:   return {ins[31:12], 12'h000};
            IMM_J:   return {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            default: return {{21{ins[31]}}, ins[30:20]};
        endcase
    endfunction

    // alt picks SUB over ADD and SRA over SRL
    function automatic alu_op_e op_for_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return alt ? ALU_SUB : ALU_ADD;
            3'd1:    return ALU_SLL;
            3'd2:    return ALU_SLT;
            3'd3:    return ALU_SLTU;
            3'd4:    return ALU_XOR;
            3'd5:    return alt ? ALU_SRA : ALU_SRL;
            3'd6:    return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic decoded_t expect_decode(input fetch_t f, input logic [XLEN-1:0] rs1_val,
                                               input logic [XLEN-1:0] rs2_val);
        decoded_t   d;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       bad;
        f3         = f.instr[14:12];
        f7         = f.instr[31:25];
        bad        = 1'b0;
        d          = DECODED_NOP;
        d.pc       = f.pc;
        d.rs1_addr = f.instr[19:15];
        d.rs2_addr = f.instr[24:20];
        d.rd_addr  = f.instr[11:7];
        d.rs1_data = rs1_val;
        d.rs2_data = rs2_val;
        d.imm      = imm_of(f.instr, IMM_I);
        d.alu_en   = 1'b1;
        case (f.instr[6:0])
            OPC_LUI: begin
                d.alu_op    = ALU_LUI;
                d.alu_src_2 = ALU_SRC_IMM;
                d.rd_we     = 1'b1;
                d.imm       = imm_of(f.instr, IMM_U);
            end
            OPC_AUIPC: begin
                d.alu_src_1 = ALU_SRC_PC;   // pc + upper immediate
                d.alu_src_2 = ALU_SRC_IMM;
                d.rd_we     = 1'b1;
                d.imm       = imm_of(f.instr, IMM_U);
            end
            OPC_JAL: begin
                d.alu_src_1 = ALU_SRC_PC;   // Link value pc + 4
                d.alu_src_2 = ALU_SRC_IMM;
                d.rd_we     = 1'b1;
                d.imm       = 32'd4;
            end
            OPC_JALR: begin
                d.alu_src_2 = ALU_SRC_IMM;
                d.rd_we     = 1'b1;
                d.wb_sel    = WB_PCINCR;
                d.branch    = BR_JALR;
            end
            OPC_BRANCH: begin
                d.imm    = imm_of(f.instr, IMM_B);
                d.branch = branch_e'({1'b0, f3});
                d.alu_op = f3[1] ? ALU_SUBU : ALU_SUB;
                bad      = (f3 == 3'd2) || (f3 == 3'd3);
            end
            OPC_LOAD: begin
                d.alu_src_2 = ALU_SRC_IMM;
                d.mem_req   = 1'b1;
                d.rd_we     = 1'b1;
                d.wb_sel    = WB_MEM;
                d.mem_size  = mem_size_e'(f3);
                bad         = (f3 == 3'd3) || (f3 > 3'd5);
            end
            OPC_STORE: begin
                d.alu_src_2 = ALU_SRC_IMM;
                d.mem_req   = 1'b1;
                d.mem_we    = 1'b1;
                d.imm       = imm_of(f.instr, IMM_S);
                d.mem_size  = mem_size_e'(f3);
                bad         = (f3 > 3'd2);
            end
            OPC_OPIMM: begin
                d.alu_src_2 = ALU_SRC_IMM;
                d.rd_we     = 1'b1;
                d.alu_op    = op_for_funct3(f3, (f3 == 3'd5) && f7[5]);
                bad         = ((f3 == 3'd1) && (f7 != 7'h00)) ||
                              ((f3 == 3'd5) && (f7 != 7'h00) && (f7 != 7'h20));
            end
            OPC_OP: begin
                d.rd_we  = 1'b1;
                d.alu_op = op_for_funct3(f3, f7[5]);
                bad      = !((f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5))));
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin
            d.alu_en   = 1'b0;
            d.rd_we    = 1'b0;
            d.mem_req  = 1'b0;
            d.mem_we   = 1'b0;
            d.branch   = BR_NOP;
            d.mem_size = MEM_NONE;
            d.illegal  = 1'b1;
        end
        return d;
    endfunction

    // ALU fields and immediate carry no meaning in an illegal slot
    function automatic decoded_t strip_dont_care(input decoded_t d);
        decoded_t s;
        s = d;
        if (d.illegal) begin
            s.alu_op    = ALU_ADD;
            s.alu_src_1 = ALU_SRC_REG;
            s.alu_src_2 = ALU_SRC_REG;
            s.wb_sel    = WB_ALU;
            s.imm       = '0;
        end
        return s;
    endfunction

    // Register read with x0 at zero and same-cycle write-back forwarded
    function automatic logic [XLEN-1:0] read_shadow(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        return (wb_we_i && (wb_addr_i == addr)) ? wb_data_i : shadow[addr];
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ifid_model <= IF_ID_RESET;
            ex_exp     <= DECODED_NOP;
            for (int i = 0; i < 32; i++) begin
                shadow[i] <= '0;
            end
        end else begin
            if (!stall_i) begin
                ex_exp     <= expect_decode(ifid_model, read_shadow(ifid_model.instr[19:15]),
                                            read_shadow(ifid_model.instr[24:20]));
                ifid_model <= clear_i ? IF_ID_RESET : fetch_i;
            end
            if (wb_we_i && (wb_addr_i != '0)) begin
                shadow[wb_addr_i] <= wb_data_i;  // Write-back is never stalled
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        assert (strip_dont_care(ex_o) == strip_dont_care(ex_exp))
            else stop_with_error($sformatf("mismatch at %0t: ex_o %h, expected %h",
                                           $time, ex_o, ex_exp));
        assert (jump_o == (ifid_model.instr[6:0] == OPC_JAL))
            else stop_with_error($sformatf("mismatch at %0t: jump_o %b for instr %h",
                                           $time, jump_o, ifid_model.instr));
        if (jump_o) begin
            assert (jump_target_o == ifid_model.pc + imm_of(ifid_model.instr, IMM_J))
                else stop_with_error($sformatf("mismatch at %0t: jump target %h, pc %h instr %h",
                                               $time, jump_target_o, ifid_model.pc,
                                               ifid_model.instr));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [6:0] pick_opcode(input int phase, input logic [31:0] r);
        case (phase)
            0: return (r[2:0] == 3'd0) ? OPC_LUI : (r[2:0] == 3'd1) ? OPC_AUIPC :
                      (r[2:0] < 3'd5)  ? OPC_OP  : OPC_OPIMM;
            1: return (r[1:0] == 2'd0) ? OPC_LOAD : (r[1:0] == 2'd1) ? OPC_STORE : OPC_BRANCH;
            2: return (r[1:0] == 2'd0) ? OPC_JAL : (r[1:0] == 2'd1) ? OPC_JALR :
                      (r[1:0] == 2'd2) ? OPC_OPIMM : OPC_BRANCH;
            3: return OPC_OP;
            default: begin
                case (r[3:0])
                    4'd0:    return OPC_LUI;
                    4'd1:    return OPC_AUIPC;
                    4'd2:    return OPC_JAL;
                    4'd3:    return OPC_JALR;
                    4'd4:    return OPC_BRANCH;
                    4'd5:    return OPC_LOAD;
                    4'd6:    return OPC_STORE;
                    4'd7:    return OPC_OPIMM;
                    4'd8:    return OPC_OP;
                    default: return r[10:4];   // Mostly unknown opcodes
                endcase
            end
        endcase
    endfunction

    // funct7 biased toward the codes that matter for OP and shifts
    function automatic logic [31:0] shape_instr(input logic [6:0] opc, input logic [31:0] r);
        logic [31:0] ins;
        ins = {r[31:7], opc};
        if ((opc == OPC_OP) || (opc == OPC_OPIMM)) begin
            if (r[1:0] == 2'd3) begin
                ins[31:25] = 7'h20;
            end else if (r[1:0] != 2'd0) begin
                ins[31:25] = 7'h00;
            end
        end
        return ins;
    endfunction

    task automatic drive_slot(input int phase);
        logic [31:0] r;
        logic [31:0] w;
        logic [31:0] p;
        r = next_rand();
        w = next_rand();
        p = next_rand();
        fetch_i.pc    = {p[31:2], 2'b00};
        fetch_i.instr = shape_instr(pick_opcode(phase, w), r);
        stall_i       = (phase == 4) && (w[14:12] < 3'd2);
        clear_i       = (phase == 4) && (w[17:15] == 3'd0);
        wb_we_i       = (phase == 3) ? (w[18] | w[19]) : w[18];
        case (w[21:20])
            2'd0:    wb_addr_i = ifid_model.instr[19:15];  // Hit the bypass
            2'd1:    wb_addr_i = ifid_model.instr[24:20];
            default: wb_addr_i = w[26:22];
        endcase
        wb_data_i = next_rand();
    endtask

    task automatic drive_idle();
        fetch_i   = IF_ID_RESET;
        stall_i   = 1'b0;
        clear_i   = 1'b0;
        wb_we_i   = 1'b0;
        wb_addr_i = '0;
        wb_data_i = '0;
    endtask

    initial begin
        arst_n = 1'b0;
        drive_idle();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            assert (!jump_o && !ex_o.alu_en && !ex_o.rd_we && !ex_o.mem_req &&
                    !ex_o.illegal && (ex_o.branch == BR_NOP))
                else stop_with_error($sformatf("mismatch at %0t: stage active in reset", $time));
        end
        arst_n = 1'b1;

        // ALU, memory and branch, jumps, register file, then stall and clear
        for (int ph = 0; ph < N_PHASES; ph++) begin
            for (int n = 0; n < PHASE_CYCLES; n++) begin
                @(negedge clk);
                drive_slot(ph);
            end
        end
        repeat (DRAIN_CYCLES) begin
            @(negedge clk);
            drive_idle();
        end
        $display("All tests passed!");
        $finish;
    end

    initial begin
        #((RESET_CYCLES + N_PHASES * PHASE_CYCLES + DRAIN_CYCLES + 50) * CLK_PERIOD);
        stop_with_error("Watchdog expired before the test sequence finished");
    end

endmodule

`default_nettype wire

// ==== compile.f ====
hdl/riscv_isa_pkg.sv
hdl/decode_ctrl_pkg.sv
hdl/stage_reg.sv
hdl/imm_gen.sv
hdl/reg_file.sv
hdl/instr_decoder.sv
hdl/decode_stage.sv
dv/tb_decode_stage.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - hdl/riscv_isa_pkg.sv
  - hdl/decode_ctrl_pkg.sv
  - hdl/stage_reg.sv
  - hdl/imm_gen.sv
  - hdl/reg_file.sv
  - hdl/instr_decoder.sv
  - hdl/decode_stage.sv
  - target: test
    files:
      - dv/tb_decode_stage.sv
